/* hdl/bwt_fwd_pkg.sv */
`default_nettype none

package bwt_fwd_pkg;

	typedef logic [63:0] bwt_idx_t;    // suffix array index or interval size
	typedef logic [8:0]  read_num_t;   // read tag
	typedef logic [6:0]  qpos_t;       // position in the read
	typedef logic [6:0]  qptr_t;       // curr queue pointer
	typedef logic [7:0]  base_t;       // query symbol
	typedef logic [31:0] dram_addr_t;  // dram line address

	// one-hot status codes, zero marks an empty slot
	typedef enum logic [5:0] {
		BUBBLE  = 6'b00_0000,
		F_INIT  = 6'b00_0001,
		F_RUN   = 6'b00_0010,
		F_BREAK = 6'b00_0100,
		BCK_INI = 6'b00_1000,
		BCK_RUN = 6'b01_0000,
		BCK_END = 6'b10_0000
	} fwd_status_e;

	typedef struct packed {
		bwt_idx_t x0;
		bwt_idx_t x1;
		bwt_idx_t x2;
		bwt_idx_t info;
	} bi_interval_t;

	typedef struct packed {
		fwd_status_e  status;
		read_num_t    read_num;
		qptr_t        ptr_curr;
		bi_interval_t ik;
		qpos_t        forward_i;
		qpos_t        min_intv;
		qpos_t        backward_x;
		base_t        query;
	} fwd_item_t;

	typedef struct packed {
		bwt_idx_t k;
		bwt_idx_t l;
		base_t    query;
	} occ_req_t;

	typedef struct packed {
		logic           we;
		read_num_t      read_num;
		qptr_t          addr;
		bwt_idx_t [3:0] data;  // {info, x2, x1, x0}
	} curr_wr_t;

	typedef struct packed {
		logic      valid;
		qpos_t     pos;
		read_num_t read_num;
	} ret_t;

	typedef struct packed {
		fwd_status_e status;
		read_num_t   read_num;
		qpos_t       position;
	} query_req_t;

	typedef struct packed {
		logic       valid;
		dram_addr_t addr_k;
		dram_addr_t addr_l;
	} dram_req_t;

endpackage

`default_nettype wire

/* hdl/fwd_entry_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fwd_entry_stage #(
	parameter int READ_LEN = 101
) (
	input  wire                     Clk_32UI,
	input  wire                     reset_BWT_extend,
	input  wire                     stall_i,
	input  wire bwt_fwd_pkg::bwt_idx_t  primary_i,
	input  wire bwt_fwd_pkg::fwd_item_t item_i,
	output bwt_fwd_pkg::fwd_item_t      item_o,
	output bwt_fwd_pkg::occ_req_t       occ_req_o
);
	import bwt_fwd_pkg::*;

	localparam qpos_t LEN = qpos_t'(READ_LEN);

	bwt_idx_t k_temp;
	bwt_idx_t l_temp;
	logic     read_done;

	assign k_temp    = item_i.ik.x1 - 64'd1;
	assign l_temp    = k_temp + item_i.ik.x2;
	assign read_done = (item_i.status == F_RUN) && (item_i.forward_i >= LEN);

	// ----------------------------------------
	// L0 register, status update and k/l request
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			item_o.status <= BUBBLE;
		end else if (!stall_i) begin
			item_o <= item_i;
			if (read_done) begin
				item_o.status <= F_BREAK;  // whole read consumed
			end

			// the sentinel row at primary is skipped in the bwt
			occ_req_o.k <= (k_temp >= primary_i) ? k_temp - 64'd1 : k_temp;
			occ_req_o.l <= (l_temp >= primary_i) ? l_temp - 64'd1 : l_temp;
			occ_req_o.query <= item_i.query;
		end
	end

endmodule

`default_nettype wire

/* hdl/occ_align_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module occ_align_pipe #(
	parameter int OCC_LATENCY = 12,
	parameter int READ_LEN    = 101
) (
	input  wire                     Clk_32UI,
	input  wire                     reset_BWT_extend,
	input  wire                     stall_i,
	input  wire bwt_fwd_pkg::fwd_item_t item_i,
	output bwt_fwd_pkg::fwd_item_t      item_o,
	output logic                    run_o,
	output logic                    break_o,
	output logic                    at_len_o
);
	import bwt_fwd_pkg::*;

	localparam qpos_t LEN = qpos_t'(READ_LEN);

	fwd_item_t pipe_q [OCC_LATENCY];  // items waiting on the occ result

	assign item_o = pipe_q[OCC_LATENCY-1];

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			for (int i = 0; i < OCC_LATENCY; i++) begin
				pipe_q[i].status <= BUBBLE;
			end
			run_o    <= 1'b0;
			break_o  <= 1'b0;
			at_len_o <= 1'b0;
		end else if (!stall_i) begin
			pipe_q[0] <= item_i;
			for (int i = 1; i < OCC_LATENCY; i++) begin
				pipe_q[i] <= pipe_q[i-1];
			end
			// flags decoded one stage early, land with the last item
			run_o    <= pipe_q[OCC_LATENCY-2].status == F_RUN;
			break_o  <= pipe_q[OCC_LATENCY-2].status == F_BREAK;
			at_len_o <= pipe_q[OCC_LATENCY-2].forward_i == LEN;
		end
	end

endmodule

`default_nettype wire

/* hdl/fwd_decide_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fwd_decide_stage (
	input  wire                        Clk_32UI,
	input  wire                        reset_BWT_extend,
	input  wire                        stall_i,
	input  wire bwt_fwd_pkg::fwd_item_t    item_i,
	input  wire                        run_i,
	input  wire                        break_i,
	input  wire                        at_len_i,
	input  wire bwt_fwd_pkg::bi_interval_t occ_resp_i,
	output bwt_fwd_pkg::fwd_item_t         item_o,
	output bwt_fwd_pkg::bi_interval_t      resp_o,
	output logic                       update_o,
	output bwt_fwd_pkg::curr_wr_t          curr_wr_o,
	output bwt_fwd_pkg::ret_t              ret_o
);
	import bwt_fwd_pkg::*;

	qptr_t ptr_next;
	logic  intv_changed;
	logic  intv_small;

	assign ptr_next     = item_i.ptr_curr + 7'd1;
	assign intv_changed = occ_resp_i.x2 != item_i.ik.x2;
	assign intv_small   = occ_resp_i.x2 < bwt_idx_t'(item_i.min_intv);

	// ----------------------------------------
	// L1 forward break decision
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			item_o.status <= BUBBLE;
			update_o      <= 1'b0;
			curr_wr_o.we  <= 1'b0;
			ret_o         <= '0;
		end else if (!stall_i) begin
			item_o <= item_i;
			resp_o <= occ_resp_i;

			curr_wr_o.read_num <= item_i.read_num;
			curr_wr_o.addr     <= item_i.ptr_curr;
			curr_wr_o.data     <= {item_i.ik.info, item_i.ik.x2, item_i.ik.x1, item_i.ik.x0};
			curr_wr_o.we       <= 1'b0;
			update_o           <= 1'b0;
			ret_o              <= '0;

			if (run_i) begin
				update_o <= 1'b1;
				if (intv_changed) begin
					curr_wr_o.we    <= 1'b1;  // keep the old interval
					item_o.ptr_curr <= ptr_next;
					if (intv_small) begin
						item_o.status <= F_BREAK;  // ik is kept as is
						update_o      <= 1'b0;
					end
				end
			end else if (break_i) begin
				if (at_len_i) begin
					curr_wr_o.we    <= 1'b1;  // read ran to the end
					item_o.ptr_curr <= ptr_next;
				end
				ret_o.valid    <= 1'b1;
				ret_o.pos      <= item_i.ik.info[6:0];
				ret_o.read_num <= item_i.read_num;
				item_o.status  <= BCK_INI;  // hand over to backward search
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/ik_update_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ik_update_stage (
	input  wire                        Clk_32UI,
	input  wire                        reset_BWT_extend,
	input  wire                        stall_i,
	input  wire bwt_fwd_pkg::fwd_item_t    item_i,
	input  wire bwt_fwd_pkg::bi_interval_t resp_i,
	input  wire                        update_i,
	output bwt_fwd_pkg::fwd_item_t         item_o,
	output bwt_fwd_pkg::bwt_idx_t          k_temp_o,
	output bwt_fwd_pkg::bwt_idx_t          l_temp_o,
	output bwt_fwd_pkg::bwt_idx_t          k_minus_o,
	output bwt_fwd_pkg::bwt_idx_t          l_minus_o
);
	import bwt_fwd_pkg::*;

	bi_interval_t next_ik;
	bwt_idx_t     k_temp;
	bwt_idx_t     l_temp;

	always_comb begin
		next_ik = item_i.ik;
		if (update_i) begin
			next_ik      = resp_i;
			next_ik.info = bwt_idx_t'(item_i.forward_i) + 64'd1;  // info = i + 1
		end
	end

	assign k_temp = next_ik.x1 - 64'd1;
	assign l_temp = k_temp + next_ik.x2;

	// ----------------------------------------
	// L2 interval update and k/l candidates
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			item_o.status <= BUBBLE;
		end else if (!stall_i) begin
			item_o    <= item_i;
			item_o.ik <= next_ik;
			if (update_i) begin
				item_o.forward_i <= item_i.forward_i + 7'd1;
			end
			k_temp_o  <= k_temp;
			l_temp_o  <= l_temp;
			k_minus_o <= k_temp - 64'd1;  // used when past primary
			l_minus_o <= l_temp - 64'd1;
		end
	end

endmodule

`default_nettype wire

/* hdl/dram_req_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_req_stage (
	input  wire                     Clk_32UI,
	input  wire                     reset_BWT_extend,
	input  wire                     stall_i,
	input  wire bwt_fwd_pkg::bwt_idx_t  primary_i,
	input  wire bwt_fwd_pkg::fwd_item_t item_i,
	input  wire bwt_fwd_pkg::bwt_idx_t  k_temp_i,
	input  wire bwt_fwd_pkg::bwt_idx_t  l_temp_i,
	input  wire bwt_fwd_pkg::bwt_idx_t  k_minus_i,
	input  wire bwt_fwd_pkg::bwt_idx_t  l_minus_i,
	output bwt_fwd_pkg::query_req_t     query_req_o,
	output bwt_fwd_pkg::dram_req_t      dram_req_o,
	output bwt_fwd_pkg::fwd_item_t      item_o
);
	import bwt_fwd_pkg::*;

	typedef struct packed {
		fwd_item_t item;
		bwt_idx_t  k_temp;
		bwt_idx_t  l_temp;
		bwt_idx_t  k_minus;
		bwt_idx_t  l_minus;
	} retime_t;

	retime_t  r1_q;
	retime_t  r2_q;
	bwt_idx_t k_sel;
	bwt_idx_t l_sel;
	logic     fwd_active;

	assign k_sel      = (r2_q.k_temp >= primary_i) ? r2_q.k_minus : r2_q.k_temp;
	assign l_sel      = (r2_q.l_temp >= primary_i) ? r2_q.l_minus : r2_q.l_temp;
	assign fwd_active = (r2_q.item.status == F_INIT) || (r2_q.item.status == F_RUN);

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			r1_q.item.status   <= BUBBLE;
			r2_q.item.status   <= BUBBLE;
			query_req_o.status <= BUBBLE;
			item_o.status      <= BUBBLE;
			dram_req_o         <= '0;
		end else if (!stall_i) begin
			r1_q <= {item_i, k_temp_i, l_temp_i, k_minus_i, l_minus_i};
			r2_q <= r1_q;

			// next query fetched a cycle before the dram request leaves
			query_req_o.status   <= r1_q.item.status;
			query_req_o.read_num <= r1_q.item.read_num;
			query_req_o.position <= r1_q.item.forward_i;

			// ----------------------------------------
			// L3 output, memory request
			if (fwd_active) begin
				dram_req_o.valid  <= 1'b1;
				dram_req_o.addr_k <= {k_sel[34:7], 4'b0};  // 128-entry bwt line
				dram_req_o.addr_l <= {l_sel[34:7], 4'b0};
			end else begin
				dram_req_o <= '0;  // break, no access
			end

			item_o <= r2_q.item;
			if (r2_q.item.status == F_INIT) begin
				item_o.status <= F_RUN;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/bwt_forward_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bwt_forward_top #(
	parameter int READ_LEN    = 101,
	parameter int OCC_LATENCY = 12
) (
	input  wire                        Clk_32UI,
	input  wire                        reset_BWT_extend,
	input  wire                        stall_i,
	input  wire bwt_fwd_pkg::bwt_idx_t     primary_i,
	input  wire bwt_fwd_pkg::fwd_item_t    item_i,
	input  wire bwt_fwd_pkg::bi_interval_t occ_resp_i,
	output bwt_fwd_pkg::occ_req_t          occ_req_o,
	output bwt_fwd_pkg::curr_wr_t          curr_wr_o,
	output bwt_fwd_pkg::ret_t              ret_o,
	output bwt_fwd_pkg::query_req_t        query_req_o,
	output bwt_fwd_pkg::dram_req_t         dram_req_o,
	output bwt_fwd_pkg::fwd_item_t         item_o
);
	import bwt_fwd_pkg::*;

	fwd_item_t    entry_item;   // L0
	fwd_item_t    align_item;   // aligned with occ result
	fwd_item_t    decide_item;  // L1
	fwd_item_t    update_item;  // L2
	bi_interval_t resp;
	logic         run, brk, at_len, update;
	bwt_idx_t     k_temp, l_temp, k_minus, l_minus;

	fwd_entry_stage #(.READ_LEN(READ_LEN)) u_entry (
		.Clk_32UI, .reset_BWT_extend, .stall_i, .primary_i, .item_i,
		.item_o(entry_item), .occ_req_o
	);

	occ_align_pipe #(.OCC_LATENCY(OCC_LATENCY), .READ_LEN(READ_LEN)) u_align (
		.Clk_32UI, .reset_BWT_extend, .stall_i, .item_i(entry_item),
		.item_o(align_item), .run_o(run), .break_o(brk), .at_len_o(at_len)
	);

	fwd_decide_stage u_decide (
		.Clk_32UI, .reset_BWT_extend, .stall_i, .item_i(align_item),
		.run_i(run), .break_i(brk), .at_len_i(at_len), .occ_resp_i,
		.item_o(decide_item), .resp_o(resp), .update_o(update), .curr_wr_o, .ret_o
	);

	ik_update_stage u_update (
		.Clk_32UI, .reset_BWT_extend, .stall_i, .item_i(decide_item),
		.resp_i(resp), .update_i(update), .item_o(update_item),
		.k_temp_o(k_temp), .l_temp_o(l_temp), .k_minus_o(k_minus), .l_minus_o(l_minus)
	);

	dram_req_stage u_dram (
		.Clk_32UI, .reset_BWT_extend, .stall_i, .primary_i, .item_i(update_item),
		.k_temp_i(k_temp), .l_temp_i(l_temp), .k_minus_i(k_minus), .l_minus_i(l_minus),
		.query_req_o, .dram_req_o, .item_o
	);

endmodule

`default_nettype wire

/* testbench/bwt_forward_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module bwt_forward_asserts #(
	parameter int READ_LEN    = 101,
	parameter int OCC_LATENCY = 12
) (
	input wire                        Clk_32UI,
	input wire                        reset_BWT_extend,
	input wire                        stall_i,
	input wire bwt_fwd_pkg::bwt_idx_t     primary_i,
	input wire bwt_fwd_pkg::fwd_item_t    item_i,
	input wire bwt_fwd_pkg::bi_interval_t occ_resp_i,
	input wire bwt_fwd_pkg::occ_req_t     occ_req_o,
	input wire bwt_fwd_pkg::curr_wr_t     curr_wr_o,
	input wire bwt_fwd_pkg::ret_t         ret_o,
	input wire bwt_fwd_pkg::query_req_t   query_req_o,
	input wire bwt_fwd_pkg::dram_req_t    dram_req_o,
	input wire bwt_fwd_pkg::fwd_item_t    item_o,
	output logic                      any_err_o
);
	import bwt_fwd_pkg::*;

	localparam qpos_t LEN       = qpos_t'(READ_LEN);
	localparam int    DECIDE_AT = OCC_LATENCY + 2;  // cycles from entry to curr/ret outputs
	localparam int    OUT_AT    = OCC_LATENCY + 6;  // cycles from entry to item_o

	typedef struct packed {
		fwd_item_t item;
		logic      we;
		logic      ret;
		logic      upd;
	} decision_t;

	typedef struct packed {
		occ_req_t   occ;
		curr_wr_t   curr;
		ret_t       ret;
		query_req_t query;
		dram_req_t  dram;
		fwd_item_t  item;
	} outs_t;

	fwd_item_t    item_q [OUT_AT];  // entered items, advancing cycles only
	bi_interval_t resp_q [5];       // responses seen by the decision stage
	outs_t        outs;
	outs_t        outs_q;
	logic         hold_q;
	decision_t    dec_now;
	decision_t    dec_qry;
	decision_t    dec_out;
	fwd_item_t    exp_item;
	occ_req_t     exp_occ;
	query_req_t   exp_query;
	dram_req_t    exp_dram;
	curr_wr_t     exp_curr;
	ret_t         exp_ret;
	logic         err_status = 1'b0;
	logic         err_item   = 1'b0;
	logic         err_occ    = 1'b0;
	logic         err_query  = 1'b0;
	logic         err_dram   = 1'b0;
	logic         err_curr   = 1'b0;
	logic         err_ret    = 1'b0;
	logic         err_hold   = 1'b0;

	// entry and decision rules applied to one entered item
	function automatic decision_t decide(fwd_item_t it, bi_interval_t r);
		decision_t d;
		d      = '0;
		d.item = it;
		if (it.status == F_RUN && it.forward_i >= LEN)
			d.item.status = F_BREAK;
		if (d.item.status == F_RUN) begin
			d.upd = 1'b1;
			if (r.x2 != it.ik.x2) begin
				d.we            = 1'b1;
				d.item.ptr_curr = it.ptr_curr + 7'd1;
				if (r.x2 < bwt_idx_t'(it.min_intv)) begin
					d.item.status = F_BREAK;
					d.upd         = 1'b0;
				end
			end
		end else if (d.item.status == F_BREAK) begin
			d.ret = 1'b1;
			if (it.forward_i == LEN) begin
				d.we            = 1'b1;
				d.item.ptr_curr = it.ptr_curr + 7'd1;
			end
			d.item.status = BCK_INI;
		end
		if (d.upd) begin
			d.item.ik        = r;
			d.item.ik.info   = bwt_idx_t'(it.forward_i) + 64'd1;
			d.item.forward_i = it.forward_i + 7'd1;
		end
		return d;
	endfunction

	function automatic bwt_idx_t skip_primary(bwt_idx_t t, bwt_idx_t prim);
		return (t >= prim) ? t - 64'd1 : t;  // skip the sentinel row
	endfunction

	function automatic dram_addr_t line_addr(bwt_idx_t t, bwt_idx_t prim);
		bwt_idx_t adj;
		adj = skip_primary(t, prim);
		return {adj[34:7], 4'b0};
	endfunction

	always_comb begin
		dec_now  = decide(item_q[DECIDE_AT-1], resp_q[0]);
		dec_qry  = decide(item_q[OUT_AT-2], resp_q[3]);
		dec_out  = decide(item_q[OUT_AT-1], resp_q[4]);
		exp_item = dec_out.item;
		if (exp_item.status == F_INIT)
			exp_item.status = F_RUN;
		exp_occ.k     = skip_primary(item_q[0].ik.x1 - 64'd1, primary_i);
		exp_occ.l     = skip_primary(item_q[0].ik.x1 - 64'd1 + item_q[0].ik.x2, primary_i);
		exp_occ.query = item_q[0].query;
		exp_query.status   = dec_qry.item.status;
		exp_query.read_num = dec_qry.item.read_num;
		exp_query.position = dec_qry.item.forward_i;
		exp_dram = '0;
		if (dec_out.item.status == F_INIT || dec_out.item.status == F_RUN) begin
			exp_dram.valid  = 1'b1;
			exp_dram.addr_k = line_addr(exp_item.ik.x1 - 64'd1, primary_i);
			exp_dram.addr_l = line_addr(exp_item.ik.x1 - 64'd1 + exp_item.ik.x2, primary_i);
		end
		exp_curr.we       = dec_now.we;
		exp_curr.read_num = item_q[DECIDE_AT-1].read_num;
		exp_curr.addr     = item_q[DECIDE_AT-1].ptr_curr;
		exp_curr.data     = {item_q[DECIDE_AT-1].ik.info, item_q[DECIDE_AT-1].ik.x2,
			item_q[DECIDE_AT-1].ik.x1, item_q[DECIDE_AT-1].ik.x0};
		exp_ret = '0;
		if (dec_now.ret) begin
			exp_ret.valid    = 1'b1;
			exp_ret.pos      = item_q[DECIDE_AT-1].ik.info[6:0];
			exp_ret.read_num = item_q[DECIDE_AT-1].read_num;
		end
	end

	assign outs      = {occ_req_o, curr_wr_o, ret_o, query_req_o, dram_req_o, item_o};
	assign any_err_o = err_status | err_item | err_occ | err_query | err_dram | err_curr
		| err_ret | err_hold;

	// ----------------------------------------
	// input history, moves on advancing cycles
	always_ff @(posedge Clk_32UI) begin
		outs_q <= outs;
		hold_q <= reset_BWT_extend && stall_i;
		if (!reset_BWT_extend) begin
			for (int i = 0; i < OUT_AT; i++)
				item_q[i] <= '0;
			for (int i = 0; i < 5; i++)
				resp_q[i] <= '0;
		end else if (!stall_i) begin
			item_q[0] <= item_i;
			for (int i = 1; i < OUT_AT; i++)
				item_q[i] <= item_q[i-1];
			resp_q[0] <= occ_resp_i;
			for (int i = 1; i < 5; i++)
				resp_q[i] <= resp_q[i-1];
		end
	end

	// ----------------------------------------
	a_status: assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		item_o.status == exp_item.status)
		else begin
			$error("CHECK FAILED item_o.status got %h exp %h", item_o.status, exp_item.status);
			err_status = 1'b1;
		end

	a_item: assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		exp_item.status != BUBBLE |-> item_o == exp_item)
		else begin
			$error("CHECK FAILED item_o got %h exp %h", item_o, exp_item);
			err_item = 1'b1;
		end

	a_occ: assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		item_q[0].status != BUBBLE |-> occ_req_o == exp_occ)
		else begin
			$error("CHECK FAILED occ_req_o got %h exp %h", occ_req_o, exp_occ);
			err_occ = 1'b1;
		end

	a_query: assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		query_req_o.status == exp_query.status
		&& (exp_query.status == BUBBLE || query_req_o == exp_query))
		else begin
			$error("CHECK FAILED query_req_o got %h exp %h", query_req_o, exp_query);
			err_query = 1'b1;
		end

	a_dram: assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		dram_req_o == exp_dram)
		else begin
			$error("CHECK FAILED dram_req_o got %h exp %h", dram_req_o, exp_dram);
			err_dram = 1'b1;
		end

	a_curr: assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		curr_wr_o.we == exp_curr.we && (!exp_curr.we || curr_wr_o == exp_curr))
		else begin
			$error("CHECK FAILED curr_wr_o got %h exp %h", curr_wr_o, exp_curr);
			err_curr = 1'b1;
		end

	a_ret: assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		ret_o == exp_ret)
		else begin
			$error("CHECK FAILED ret_o got %h exp %h", ret_o, exp_ret);
			err_ret = 1'b1;
		end

	a_hold: assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		hold_q |-> outs == outs_q)
		else begin
			$error("CHECK FAILED outputs under stall got %h exp %h", outs, outs_q);
			err_hold = 1'b1;
		end

endmodule

`default_nettype wire

/* testbench/tb_bwt_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bwt_forward;
	import bwt_fwd_pkg::*;

	localparam int NUM_ITEMS   = 500;
	localparam int CYCLE_LIMIT = NUM_ITEMS * 5 + 500;  // items, stall bursts and drain
	localparam int OCC_LAT     = 12;

	logic         Clk_32UI;
	logic         reset_BWT_extend;
	logic         stall_i;
	bwt_idx_t     primary_i;
	fwd_item_t    item_i;
	bi_interval_t occ_resp_i;
	occ_req_t     occ_req_o;
	curr_wr_t     curr_wr_o;
	ret_t         ret_o;
	query_req_t   query_req_o;
	dram_req_t    dram_req_o;
	fwd_item_t    item_o;

	logic [31:0]  lfsr_state;
	int           cycle_cnt;
	int           sent;
	int           burst;
	occ_req_t     occ_q [OCC_LAT];      // requests in flight in the occ model
	bwt_idx_t     ikx2_q [OCC_LAT+1];   // entered ik x2, one stage ahead of occ_q

	bwt_forward_top bwt_forward_i (
		.Clk_32UI, .reset_BWT_extend, .stall_i, .primary_i, .item_i, .occ_resp_i,
		.occ_req_o, .curr_wr_o, .ret_o, .query_req_o, .dram_req_o, .item_o
	);

	bind bwt_forward_top bwt_forward_asserts #(
		.READ_LEN(READ_LEN), .OCC_LATENCY(OCC_LATENCY)
	) u_asserts (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.primary_i(primary_i), .item_i(item_i), .occ_resp_i(occ_resp_i),
		.occ_req_o(occ_req_o), .curr_wr_o(curr_wr_o), .ret_o(ret_o),
		.query_req_o(query_req_o), .dram_req_o(dram_req_o), .item_o(item_o),
		.any_err_o()
	);

	// galois lfsr, one step per bit taken
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
			v = {v[62:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic fwd_item_t make_item();
		fwd_item_t   it;
		logic [1:0]  sel;
		it  = '0;
		sel = 2'(rand_bits(2));
		case (sel)
			2'd0: return it;  // empty slot
			2'd1: it.status = F_INIT;
			2'd2: it.status = F_RUN;
			default: it.status = F_BREAK;
		endcase
		it.read_num   = read_num_t'(rand_bits(9));
		it.ptr_curr   = qptr_t'(rand_bits(7));
		it.ik.x0      = rand_bits(40);
		it.ik.x1      = primary_i - 64'd32 + rand_bits(6);  // k/l straddle primary often
		it.ik.x2      = rand_bits(5);
		it.ik.info    = rand_bits(7);
		it.forward_i  = 7'd96 + 7'(rand_bits(3));
		it.min_intv   = qpos_t'(rand_bits(4));
		it.backward_x = qpos_t'(rand_bits(7));
		it.query      = base_t'(rand_bits(8));
		return it;
	endfunction

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	initial begin
		Clk_32UI = 1'b0;
		forever #4 Clk_32UI = ~Clk_32UI;
	end

	// ----------------------------------------
	// occurrence unit model
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			for (int i = 0; i < OCC_LAT; i++)
				occ_q[i] <= '0;
			for (int i = 0; i <= OCC_LAT; i++)
				ikx2_q[i] <= '0;
		end else if (!stall_i) begin
			occ_q[0]  <= occ_req_o;
			ikx2_q[0] <= item_i.ik.x2;
			for (int i = 1; i < OCC_LAT; i++)
				occ_q[i] <= occ_q[i-1];
			for (int i = 1; i <= OCC_LAT; i++)
				ikx2_q[i] <= ikx2_q[i-1];
		end
	end

	always_comb begin
		occ_resp_i.x0   = occ_q[OCC_LAT-1].k;
		occ_resp_i.x1   = occ_q[OCC_LAT-1].k + 64'd1;
		occ_resp_i.x2   = occ_q[OCC_LAT-1].query[0] ? ikx2_q[OCC_LAT]
			: occ_q[OCC_LAT-1].l - occ_q[OCC_LAT-1].k;
		occ_resp_i.info = '0;
	end

	always @(posedge Clk_32UI) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT)
			report_failure("timeout, the stimulus did not finish within the cycle limit");
	end

	always @(negedge Clk_32UI) begin
		if (bwt_forward_i.u_asserts.any_err_o)
			report_failure("an assertion on the DUT outputs failed");
	end

	// ----------------------------------------
	// stimulus
	initial begin
		lfsr_state       = 32'hee3b_9bf6;
		cycle_cnt        = 0;
		reset_BWT_extend = 1'b0;
		stall_i          = 1'b0;
		primary_i        = '0;
		item_i           = '0;
		sent             = 0;
		burst            = 0;
		repeat (4) @(negedge Clk_32UI);
		primary_i        = rand_bits(40);
		reset_BWT_extend = 1'b1;
		repeat (6) @(negedge Clk_32UI);  // idle, outputs stay empty

		while (sent < NUM_ITEMS) begin
			@(negedge Clk_32UI);
			if (burst > 0) begin
				stall_i = 1'b1;
				burst--;
			end else if (rand_bits(3) == 64'd0) begin
				stall_i = 1'b1;
				burst   = int'(rand_bits(2));
			end else begin
				stall_i = 1'b0;
				item_i  = make_item();
				sent++;
			end
		end

		@(negedge Clk_32UI);
		stall_i = 1'b0;
		item_i  = '0;
		repeat (40) @(negedge Clk_32UI);  // drain the pipe

		if (bwt_forward_i.u_asserts.any_err_o) begin
			report_failure("an assertion on the DUT outputs failed");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* bwt_forward.f */
hdl/bwt_fwd_pkg.sv
hdl/fwd_entry_stage.sv
hdl/occ_align_pipe.sv
hdl/fwd_decide_stage.sv
hdl/ik_update_stage.sv
hdl/dram_req_stage.sv
hdl/bwt_forward_top.sv
testbench/bwt_forward_asserts.sv
testbench/tb_bwt_forward.sv

/* Makefile */
SIM  := obj_dir/Vtb_bwt_forward
SRCS := $(wildcard hdl/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) bwt_forward.f
	verilator --binary --timing --assert -j 0 --top-module tb_bwt_forward -f bwt_forward.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "Result: PASSED" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
